//--- rtl/board_params.svh
/*
 * Build-time constants of the board register block.
 * Include wherever a size or a fixed value is needed; the guard makes
 * repeated inclusion harmless.
 */
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// version word returned by REG_VERSION, ascii "QLA1"
`define BOARD_VERSION   32'h514C4131

// channel count, reported in status bits 31..28
`define NUM_CHAN        4'd4

// bus byte address: bits 5..2 pick the register, bits 7..6 must be zero
`define AXIL_ADDR_W     8

// amp hold-off after mv_good rises, in sysclk cycles (short for sim)
`define MV_GOOD_CYCLES  64

// watchdog period register width
`define WDOG_PERIOD_W   16

`endif

//--- rtl/board_reg_pkg.sv
/*
 * Register map of the board block: register indices as seen on the
 * internal register port, and the watchdog period type shared by the
 * register file and the watchdog timer.
 */
`default_nettype none

`include "board_params.svh"

package board_reg_pkg;

    // register index, byte address bits 5..2
    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,     // status / control, masked writes
        REG_WDOG    = 4'd3,     // watchdog period
        REG_VERSION = 4'd4,     // read only
        REG_TEMPSNS = 4'd5,     // temperature, zero extended
        REG_DIGIOUT = 4'd6,     // digital output word
        REG_DSSTAT  = 4'd10,    // 1-wire chip status
        REG_DIGIN   = 4'd11     // packed digital inputs
    } reg_index_t;

    // watchdog period, 0 disables
    typedef logic [`WDOG_PERIOD_W-1:0] wdog_period_t;

endpackage

`default_nettype wire

//--- rtl/axil_pkg.sv
/*
 * AXI4-Lite definitions used by the bus bridge: the bridge FSM states
 * and the response codes returned on bresp / rresp.
 */
`default_nettype none

package axil_pkg;

    // one transaction in flight at a time
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,    // waiting for aw+w or ar
        ST_WRITE = 3'd1,    // write accepted, strobe issued next
        ST_WRESP = 3'd2,    // strobe cycle, then bvalid until bready
        ST_READ  = 3'd3,    // register file registers read data
        ST_RDATA = 3'd4     // capture, then rvalid until rready
    } axil_state_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2  // upper address bits non-zero
    } axil_resp_t;

endpackage

`default_nettype wire

//--- rtl/axil_reg_bridge.sv
/*
 * AXI4-Lite slave front end of the board register file.
 * Each bus transaction becomes a single-cycle write strobe or a read
 * address on the internal register port. One transaction is handled at
 * a time; a write waiting alongside a read goes first. Addresses with
 * bits 7..6 set get SLVERR, no strobe, and zero read data.
 */
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module axil_reg_bridge (
    input  logic                      sysclk,
    input  logic                      rst,
    // AXI4-Lite slave
    input  logic [`AXIL_ADDR_W-1:0]   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output axil_pkg::axil_resp_t      bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AXIL_ADDR_W-1:0]   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output axil_pkg::axil_resp_t      rresp,
    output logic                      rvalid,
    input  logic                      rready,
    // register port
    output board_reg_pkg::reg_index_t reg_waddr,
    output board_reg_pkg::reg_index_t reg_raddr,
    output logic [31:0]               reg_wdata,
    output logic                      reg_wen,
    input  logic [31:0]               reg_rdata
);
    import axil_pkg::*;
    import board_reg_pkg::*;

    axil_state_t state;
    logic        addr_err;      // upper address bits of the accepted item
    logic        wr_go;         // aw and w both taken this cycle
    logic        rd_go;         // ar taken this cycle

    // ready only in idle, write has priority over read
    assign wr_go   = (state == ST_IDLE) && awvalid && wvalid;
    assign rd_go   = (state == ST_IDLE) && arvalid && !wr_go;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    // ------------------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state   <= ST_IDLE;
            reg_wen <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            reg_wen <= 1'b0;                        // strobe is one cycle
            case (state)
                ST_IDLE: begin
                    if (wr_go)
                        state <= ST_WRITE;
                    else if (rd_go)
                        state <= ST_READ;
                end
                ST_WRITE: begin
                    reg_wen <= !addr_err;           // no strobe on bad address
                    state   <= ST_WRESP;
                end
                ST_WRESP: begin
                    if (!bvalid) begin
                        bvalid <= 1'b1;             // after the strobe cycle
                    end else if (bready) begin
                        bvalid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                ST_READ: state <= ST_RDATA;         // reg_rdata settles here
                ST_RDATA: begin
                    if (!rvalid) begin
                        rvalid <= 1'b1;
                    end else if (rready) begin
                        rvalid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address, data and response capture
    always_ff @(posedge sysclk) begin
        if (wr_go) begin
            reg_waddr <= reg_index_t'(awaddr[5:2]);
            reg_wdata <= wdata;
            addr_err  <= |awaddr[`AXIL_ADDR_W-1:6];
        end else if (rd_go) begin
            reg_raddr <= reg_index_t'(araddr[5:2]);
            addr_err  <= |araddr[`AXIL_ADDR_W-1:6];
        end
        if (state == ST_WRESP && !bvalid)
            bresp <= addr_err ? RESP_SLVERR : RESP_OKAY;
        if (state == ST_RDATA && !rvalid) begin
            rresp <= addr_err ? RESP_SLVERR : RESP_OKAY;
            rdata <= addr_err ? 32'd0 : reg_rdata;  // held while rvalid
        end
    end

endmodule

`default_nettype wire

//--- rtl/board_regs.sv
/*
 * Board status/control register file of the four-axis controller.
 * Status writes use enable/mask pairs: only masked bits change. Bits 24..22
 * fire one-cycle reset pulses. Amplifiers stay disabled until mv_good has
 * been stable for the hold-off time, and drop on watchdog timeout or a
 * safety disable. Read data is registered one cycle after reg_raddr.
 */
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module board_regs (
    input  logic                        sysclk,
    input  logic                        rst,
    // register port
    input  board_reg_pkg::reg_index_t   reg_waddr,
    input  board_reg_pkg::reg_index_t   reg_raddr,
    input  logic [31:0]                 reg_wdata,
    input  logic                        reg_wen,
    output logic [31:0]                 reg_rdata,
    // watchdog link
    output board_reg_pkg::wdog_period_t wdog_period,
    output logic                        wdog_clear,
    input  logic                        wdog_timeout,
    // board inputs
    input  logic [31:0]                 dout,
    input  logic                        dout_cfg_valid,
    input  logic                        dout_cfg_bidir,
    input  logic                        quad_dac,       // 1 = single quad DAC
    input  logic                        ioexp_present,
    input  logic [3:0]                  enc_a,
    input  logic [3:0]                  enc_b,
    input  logic [3:0]                  enc_i,
    input  logic [3:0]                  neg_limit,
    input  logic [3:0]                  pos_limit,
    input  logic [3:0]                  home,
    input  logic [3:0]                  fault,          // 1 = amp ok
    input  logic                        relay,
    input  logic                        mv_faultn,      // active low
    input  logic                        mv_good,
    input  logic                        v_fault,
    input  logic                        safety_fb,
    input  logic                        mv_fb,
    input  logic [3:0]                  board_id,
    input  logic [15:0]                 temp_sense,
    input  logic [31:0]                 ds_status,
    input  logic [3:0]                  safety_amp_disable,
    // board outputs
    output logic [3:0]                  amp_disable,
    output logic                        pwr_enable,
    output logic                        relay_on,
    output logic                        dout_cfg_reset,
    output logic                        dac_test_reset,
    output logic                        ioexp_cfg_reset
);
    import board_reg_pkg::*;

    localparam int MV_CNT_W = $clog2(`MV_GOOD_CYCLES + 1);

    logic [3:0]          reg_disable;   // host/safety disable per axis
    logic [MV_CNT_W-1:0] mv_good_cnt;   // cycles since mv_good rose
    logic                mv_hold;       // hold-off still running
    logic                write_status;
    logic                pwr_enable_cmd;
    logic [3:0]          amp_enable_cmd;
    logic [31:0]         reg_status;
    logic [31:0]         reg_digin;

    // board id in 27..24 and wdog_timeout in 23 are fixed by host software
    assign reg_status = {`NUM_CHAN, board_id,
                         wdog_timeout, quad_dac, dout_cfg_valid, dout_cfg_bidir,
                         mv_good, pwr_enable, ~relay, relay_on,
                         ~mv_faultn, safety_fb, 1'b0, ioexp_present,
                         fault, safety_amp_disable, ~reg_disable};

    // dout[31] flags the waveform table driving a dout
    assign reg_digin = {v_fault, 1'b0, dout[31], mv_fb, enc_a, enc_b, enc_i,
                        dout[3:0], neg_limit, pos_limit, home};

    // ------------------------------------------------------------------------
    // host commands
    // ------------------------------------------------------------------------
    assign write_status   = reg_wen && (reg_waddr == REG_STATUS);
    assign pwr_enable_cmd = write_status && reg_wdata[19] && reg_wdata[18];
    assign amp_enable_cmd = write_status ? (reg_wdata[11:8] & reg_wdata[3:0]) : 4'd0;
    assign wdog_clear     = pwr_enable_cmd || (|amp_enable_cmd);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_disable     <= 4'hf;            // everything off at power up
            pwr_enable      <= 1'b0;
            relay_on        <= 1'b0;
            dout_cfg_reset  <= 1'b0;
            dac_test_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
            wdog_period     <= '0;              // watchdog off
        end else begin
            dac_test_reset  <= 1'b0;            // pulses drop unless rewritten
            ioexp_cfg_reset <= 1'b0;
            dout_cfg_reset  <= 1'b0;
            if (write_status) begin
                // bits 11..8 mask 3..0, axis forced off while power is off
                for (int i = 0; i < 4; i++) begin
                    reg_disable[i] <= !pwr_enable ||
                                      (reg_wdata[8+i] ? !reg_wdata[i] : reg_disable[i]);
                end
                relay_on        <= reg_wdata[17] ? reg_wdata[16] : relay_on;
                pwr_enable      <= reg_wdata[19] ? reg_wdata[18] : pwr_enable;
                dac_test_reset  <= reg_wdata[22];
                ioexp_cfg_reset <= reg_wdata[23];
                dout_cfg_reset  <= reg_wdata[24];
            end else if (reg_wen && reg_waddr == REG_WDOG) begin
                wdog_period <= reg_wdata[`WDOG_PERIOD_W-1:0];
            end
            if (!reg_wen) begin
                // sticky, only an enable write brings an axis back
                reg_disable <= reg_disable | (wdog_timeout ? 4'hf : safety_amp_disable);
            end
        end
    end

    // read mux, unmapped indices read zero
    always_ff @(posedge sysclk) begin
        case (reg_raddr)
            REG_STATUS:  reg_rdata <= reg_status;
            REG_WDOG:    reg_rdata <= 32'(wdog_period);
            REG_VERSION: reg_rdata <= `BOARD_VERSION;
            REG_TEMPSNS: reg_rdata <= {16'd0, temp_sense};
            REG_DIGIOUT: reg_rdata <= dout;
            REG_DSSTAT:  reg_rdata <= ds_status;
            REG_DIGIN:   reg_rdata <= reg_digin;
            default:     reg_rdata <= 32'd0;
        endcase
    end

    // ------------------------------------------------------------------------
    // motor voltage hold-off
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst || !mv_good)
            mv_good_cnt <= '0;                  // restart on every drop
        else if (mv_hold)
            mv_good_cnt <= mv_good_cnt + 1'b1;
    end

    assign mv_hold     = (mv_good_cnt != MV_CNT_W'(`MV_GOOD_CYCLES));
    assign amp_disable = reg_disable | {4{mv_hold}};

endmodule

`default_nettype wire

//--- rtl/wdog_timer.sv
/*
 * Host-silence watchdog. Counts sysclk cycles since the last register
 * write and raises a sticky timeout at the programmed period.
 * A period of zero turns it off; wdog_clear drops the flag.
 */
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module wdog_timer (
    input  logic                        sysclk,
    input  logic                        rst,
    input  board_reg_pkg::wdog_period_t wdog_period,
    input  logic                        reg_wen,        // any host write kicks
    input  logic                        wdog_clear,
    output logic                        wdog_timeout
);
    logic [`WDOG_PERIOD_W-1:0] wdog_cnt;
    logic                      wdog_on;
    logic                      expired;

    assign wdog_on = (wdog_period != '0);
    assign expired = wdog_on && (wdog_cnt == wdog_period);

    always_ff @(posedge sysclk) begin
        if (rst || reg_wen || !wdog_on)
            wdog_cnt <= '0;
        else if (!expired)
            wdog_cnt <= wdog_cnt + 1'b1;    // saturates at the period
    end

    always_ff @(posedge sysclk) begin
        if (rst || wdog_clear)
            wdog_timeout <= 1'b0;
        else if (expired)
            wdog_timeout <= 1'b1;           // sticky
    end

endmodule

`default_nettype wire

//--- rtl/board_ctrl_top.sv
/*
 * Top of the board register block: AXI4-Lite bridge in front of the
 * register file, with the watchdog timer beside it.
 */
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module board_ctrl_top (
    input  logic                    sysclk,
    input  logic                    rst,
    // AXI4-Lite slave
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output axil_pkg::axil_resp_t    bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output axil_pkg::axil_resp_t    rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // board inputs
    input  logic [31:0]             dout,
    input  logic                    dout_cfg_valid,
    input  logic                    dout_cfg_bidir,
    input  logic                    quad_dac,
    input  logic                    ioexp_present,
    input  logic [3:0]              enc_a,
    input  logic [3:0]              enc_b,
    input  logic [3:0]              enc_i,
    input  logic [3:0]              neg_limit,
    input  logic [3:0]              pos_limit,
    input  logic [3:0]              home,
    input  logic [3:0]              fault,
    input  logic                    relay,
    input  logic                    mv_faultn,
    input  logic                    mv_good,
    input  logic                    v_fault,
    input  logic                    safety_fb,
    input  logic                    mv_fb,
    input  logic [3:0]              board_id,
    input  logic [15:0]             temp_sense,
    input  logic [31:0]             ds_status,
    input  logic [3:0]              safety_amp_disable,
    // board outputs
    output logic [3:0]              amp_disable,
    output logic                    pwr_enable,
    output logic                    relay_on,
    output logic                    dout_cfg_reset,
    output logic                    dac_test_reset,
    output logic                    ioexp_cfg_reset
);
    import board_reg_pkg::*;

    // internal register port
    reg_index_t   reg_waddr;
    reg_index_t   reg_raddr;
    logic [31:0]  reg_wdata;
    logic         reg_wen;
    logic [31:0]  reg_rdata;

    // watchdog link
    wdog_period_t wdog_period;
    logic         wdog_clear;
    logic         wdog_timeout;

    // all port names match the nets above, so connect by name
    axil_reg_bridge u_bridge (.*);

    board_regs u_regs (.*);

    wdog_timer u_wdog (.*);

endmodule

`default_nettype wire

//--- sim/board_ctrl_props.sv
/*
 * Concurrent checks on the board register block, bound into board_ctrl_top.
 * Covers the AXI4-Lite valid hold rules, the single-cycle register strobe,
 * the one-shot reset pulses and the amp disable forced by the watchdog.
 */
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_props (
    input wire logic       sysclk,
    input wire logic       rst,
    input wire logic       awvalid,
    input wire logic       awready,
    input wire logic       wvalid,
    input wire logic       wready,
    input wire logic       arvalid,
    input wire logic       arready,
    input wire logic       bvalid,
    input wire logic       bready,
    input wire logic       rvalid,
    input wire logic       rready,
    input wire logic       reg_wen,
    input wire logic       dout_cfg_reset,
    input wire logic       dac_test_reset,
    input wire logic       ioexp_cfg_reset,
    input wire logic       wdog_timeout,
    input wire logic [3:0] amp_disable
);
    int fail_count = 0;     // failed assertions, watched by the testbench

    // valid stays up until the transfer
    a_aw_hold: assert property (@(posedge sysclk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else begin
            fail_count++;
            $error("awvalid dropped");
        end
    a_w_hold: assert property (@(posedge sysclk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else begin
            fail_count++;
            $error("wvalid dropped");
        end
    a_ar_hold: assert property (@(posedge sysclk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else begin
            fail_count++;
            $error("arvalid dropped");
        end
    a_b_hold: assert property (@(posedge sysclk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped");
        end
    a_r_hold: assert property (@(posedge sysclk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped");
        end

    a_wen_single: assert property (@(posedge sysclk) disable iff (rst)
        reg_wen |=> !reg_wen)
        else begin
            fail_count++;
            $error("reg_wen longer than one cycle");
        end

    // reset pulses are one-shots
    a_pulses: assert property (@(posedge sysclk) disable iff (rst)
        (dout_cfg_reset || dac_test_reset || ioexp_cfg_reset)
        |=> !(dout_cfg_reset || dac_test_reset || ioexp_cfg_reset))
        else begin
            fail_count++;
            $error("reset pulse longer than one cycle");
        end

    // one cycle lag while the disables pick up the timeout
    a_wdog_off: assert property (@(posedge sysclk) disable iff (rst)
        wdog_timeout && $past(wdog_timeout) |-> amp_disable == 4'hf)
        else begin
            fail_count++;
            $error("axis enabled during watchdog timeout");
        end

endmodule

`default_nettype wire

//--- sim/board_ctrl_tb.sv
/*
 * Trace-driven testbench of the board register block.
 * Reads sim/board_ctrl_trace.txt, runs each line as an AXI4-Lite access,
 * a board input change, an output pin check or a delay, and compares
 * every response with the value the trace or the driven inputs call for.
 */
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module board_ctrl_tb;
    import axil_pkg::*;

    logic sysclk, rst;
    logic [`AXIL_ADDR_W-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    axil_resp_t bresp, rresp;
    logic [31:0] dout, ds_status;
    logic dout_cfg_valid, dout_cfg_bidir, quad_dac, ioexp_present;
    logic [3:0] enc_a, enc_b, enc_i, neg_limit, pos_limit, home, fault;
    logic relay, mv_faultn, mv_good, v_fault, safety_fb, mv_fb;
    logic [3:0] board_id, safety_amp_disable, amp_disable;
    logic [15:0] temp_sense;
    logic pwr_enable, relay_on, dout_cfg_reset, dac_test_reset, ioexp_cfg_reset;

    integer seed = 32'hfe2c;
    integer error_count = 0;
    integer cycles = 0;
    integer limit = 0;          // 0 until the trace has been read
    integer pulse_cycles = 0;   // cycles with any reset pulse high
    logic [7:0]  op_q[$];
    logic [31:0] sel_q[$], dat_q[$], exp_q[$];

    board_ctrl_top DUT (.*);

    bind board_ctrl_top board_ctrl_props props (.*);

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    // run limit, set from the trace length
    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run exceeded %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "run stopped by timeout");
        end
    end

    // one count per pulse cycle, a good one-shot adds exactly one
    always @(posedge sysclk) begin
        if (!rst && (dout_cfg_reset || dac_test_reset || ioexp_cfg_reset))
            pulse_cycles <= pulse_cycles + 1;
    end

    // bound assertions count their failures
    always @(negedge sysclk) begin
        if (DUT.props.fail_count != 0) begin
            $display("a bound assertion failed at %0t", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_with(input string why);
        error_count++;
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    // ------------------------------------------------------------------------
    // bus driver, handshakes sampled at the rising edge before the update
    // ------------------------------------------------------------------------
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge sysclk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do @(posedge sysclk); while (!(awready && wready));
        @(negedge sysclk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge sysclk); while (!bvalid);
        resp = bresp;
        @(negedge sysclk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge sysclk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(posedge sysclk); while (!arready);
        @(negedge sysclk);
        arvalid = 1'b0;
        do @(posedge sysclk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(negedge sysclk);
        rready = 1'b0;
    endtask

    // read data of the registers that follow the board inputs
    function automatic logic [31:0] input_reg_value(input logic [7:0] addr,
                                                    input logic [31:0] traced);
        case (addr)
            8'h14:   return {16'd0, temp_sense};
            8'h18:   return dout;
            8'h28:   return ds_status;
            8'h2c:   return {v_fault, 1'b0, dout[31], mv_fb, enc_a, enc_b, enc_i,
                             dout[3:0], neg_limit, pos_limit, home};
            default: return traced;
        endcase
    endfunction

    task automatic run_line(input logic [7:0] op, input logic [31:0] sel,
                            input logic [31:0] dat, input logic [31:0] expected);
        logic [31:0] got;
        logic [1:0]  resp;
        integer      pulses_before;
        case (op)
            "W": begin
                pulses_before = pulse_cycles;
                axi_write(sel[7:0], dat, resp);
                check_value("bresp", resp, expected);
                // only an accepted status write with bits 24..22 fires pulses
                check_value("reset pulse cycles", pulse_cycles - pulses_before,
                            (sel[7:2] == 6'd0 && dat[24:22] != 3'd0) ? 32'd1 : 32'd0);
            end
            "R": begin
                axi_read(sel[7:0], got, resp);
                check_value("rdata", got, input_reg_value(sel[7:0], dat));
                check_value("rresp", resp, expected);
            end
            "S": begin
                @(negedge sysclk);
                case (sel)
                    0: mv_good = dat[0];
                    1: safety_amp_disable = dat[3:0];
                    2: begin
                        temp_sense = $random(seed);
                        dout       = $random(seed);
                        ds_status  = $random(seed);
                    end
                    default: stop_with("trace sets an unknown input group");
                endcase
            end
            "P": begin
                @(negedge sysclk);
                case (sel)
                    0: check_value("amp_disable", amp_disable, dat);
                    1: check_value("pwr_enable", pwr_enable, dat);
                    2: check_value("relay_on", relay_on, dat);
                    default: stop_with("trace checks an unknown output pin");
                endcase
            end
            "D": repeat (sel) @(posedge sysclk);
            default: stop_with("trace holds an unknown operation");
        endcase
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        integer fd, n, delays, bus_ops;
        string  line;
        logic [7:0]  op;
        logic [31:0] sel, dat, expected;
        rst = 1'b1;
        {awaddr, awvalid, wdata, wvalid, bready} = '0;
        {araddr, arvalid, rready} = '0;
        {dout, ds_status, temp_sense} = '0;
        {dout_cfg_valid, dout_cfg_bidir, quad_dac, ioexp_present} = '0;
        {enc_a, enc_b, enc_i, neg_limit, pos_limit, home, fault} = '0;
        {relay, mv_good, v_fault, safety_fb, mv_fb} = '0;
        mv_faultn = 1'b1;                           // no motor supply fault
        board_id = 4'd0;
        safety_amp_disable = 4'd0;
        fd = $fopen("sim/board_ctrl_trace.txt", "r");
        if (fd == 0)
            stop_with("cannot open the trace file");
        delays  = 0;
        bus_ops = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", op, sel, dat, expected);
                if (n != 4)
                    stop_with("trace line is malformed");
                op_q.push_back(op);
                sel_q.push_back(sel);
                dat_q.push_back(dat);
                exp_q.push_back(expected);
                if (op == "D")
                    delays += sel;
                else
                    bus_ops++;
            end
        end
        $fclose(fd);
        limit = 20 * delays + 50 * bus_ops + 20;    // plus reset time
        repeat (10) @(posedge sysclk);
        @(negedge sysclk);
        rst = 1'b0;
        foreach (op_q[i])
            run_line(op_q[i], sel_q[i], dat_q[i], exp_q[i]);
        repeat (2) @(negedge sysclk);
        if (error_count == 0 && DUT.props.fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- board_ctrl_top.f
+incdir+rtl
rtl/board_reg_pkg.sv
rtl/axil_pkg.sv
rtl/axil_reg_bridge.sv
rtl/board_regs.sv
rtl/wdog_timer.sv
rtl/board_ctrl_top.sv
sim/board_ctrl_props.sv
sim/board_ctrl_tb.sv

//--- sim/board_ctrl_trace.txt
# op addr_or_sel data expect  (all hex)  W: addr wdata bresp  R: addr rdata rresp
# S: sel value (0 mv_good, 1 safety, 2 random data)  P: sel value (0 amp_disable, 1 pwr, 2 relay)  D: cycles
R 10 514c4131 0
S 2 0 0
R 14 0 0
R 18 0 0
R 28 0 0
R 2c 0 0
R 1c 0 0
R 00 40020000 0
W 00 00000a0a 0
R 00 40020000 0
W 00 000c0000 0
W 00 00000a0a 0
R 00 4006000a 0
P 0 f 0
S 0 1 0
D 50 0 0
P 0 5 0
W 00 00030005 0
R 00 400f000a 0
P 2 1 0
S 0 0 0
D 2 0 0
S 0 1 0
D 5 0 0
P 0 f 0
D 50 0 0
P 0 5 0
W 0c 00000014 0
R 0c 00000014 0
D 28 0 0
R 00 408f0000 0
P 0 f 0
W 0c 00000000 0
W 00 000c0000 0
R 00 400f0000 0
D 64 0 0
R 00 400f0000 0
W 00 00000a0a 0
P 0 5 0
S 1 2 0
D 3 0 0
P 0 7 0
S 1 0 0
D 3 0 0
R 00 400f0008 0
W 00 00000a0a 0
P 0 5 0
W 40 00080000 2
R 40 00000000 2
R 00 400f000a 0
P 1 1 0
